/* hdl/rsu_pkg.sv */
// remote-update package: widths, typedefs, sequencer states, core and config structs, CSR map
`default_nettype none

package rsu_pkg;

  localparam int rsu_data_w     = 24;
  localparam int rsu_readback_w = 29;
  localparam int wb_data_w      = 32;

  typedef logic [2:0]                rsu_param_t;
  typedef logic [1:0]                rsu_source_t;
  typedef logic [rsu_data_w-1:0]     rsu_data_t;
  typedef logic [rsu_readback_w-1:0] rsu_readback_t;
  typedef logic [3:0]                rsu_cause_t;
  typedef logic [wb_data_w-1:0]      wb_data_t;
  typedef logic [1:0]                wb_adr_t;

  // update core parameter selectors
  localparam rsu_param_t param_mode  = 3'b000;
  localparam rsu_param_t param_wdog  = 3'b010;
  localparam rsu_param_t param_boot  = 3'b100;
  // trigger condition, holds the error cause of the last config
  localparam rsu_param_t param_cause = 3'b111;

  localparam rsu_source_t src_current  = 2'b00;
  localparam rsu_source_t src_previous = 2'b01;

  typedef enum logic [3:0] {
    idle_wait,
    read_mode_req,
    read_mode_wait,
    read_mode_eval,
    read_status_req,
    read_status_wait,
    read_status_eval,
    write_wd_req,
    write_wd_wait,
    write_addr_req,
    write_addr_wait,
    reconfig,
    done
  } rsu_state_t;

  typedef struct packed {
    logic        read_param;
    logic        write_param;
    rsu_param_t  param;
    rsu_source_t read_source;
    rsu_data_t   data_in;
    logic        reconfig;
    logic        reset_timer;
  } rsu_core_req_t;

  typedef struct packed {
    logic          busy;
    rsu_readback_t data_out;
  } rsu_core_rsp_t;

  typedef struct packed {
    rsu_data_t boot_addr;
    rsu_data_t watchdog;
    logic      force_factory;
    logic      reboot_req;
  } rsu_cfg_t;

  // msb first, lines up with the status register bits
  typedef struct packed {
    logic       finished;
    rsu_cause_t cause;
    logic       app_mode;
    rsu_state_t state;
  } rsu_status_t;

  localparam wb_adr_t reg_ctrl   = 2'd0;
  localparam wb_adr_t reg_boot   = 2'd1;
  localparam wb_adr_t reg_wdog   = 2'd2;
  localparam wb_adr_t reg_status = 2'd3;

endpackage

`default_nettype wire

/* hdl/rsu_sequencer.sv */
// boot-decision FSM driving the remote-update core parameter read/write protocol
`timescale 1ns/1ps
`default_nettype none

module rsu_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  rsu_pkg::rsu_cfg_t      cfg,
  input  rsu_pkg::rsu_core_rsp_t core_rsp,
  output rsu_pkg::rsu_core_req_t core_req,
  output rsu_pkg::rsu_status_t   status
);

  rsu_pkg::rsu_state_t state;
  rsu_pkg::rsu_data_t  data_q;
  rsu_pkg::rsu_cause_t cause_q;
  rsu_pkg::rsu_cause_t rd_cause;
  logic                app_mode_q;
  logic                rd_app_mode;
  logic                timer_q;
  logic                busy;

  assign busy        = core_rsp.busy;
  assign rd_app_mode = core_rsp.data_out[0];
  assign rd_cause    = core_rsp.data_out[4:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= rsu_pkg::idle_wait;
      app_mode_q <= 1'b0;
      cause_q    <= '0;
    end else begin
      case (state)
        rsu_pkg::idle_wait: begin
          // core may still be busy coming out of its own reset
          if (!busy) begin
            state <= rsu_pkg::read_mode_req;
          end
        end
        rsu_pkg::read_mode_req: begin
          state <= rsu_pkg::read_mode_wait;
        end
        rsu_pkg::read_mode_wait: begin
          if (!busy) begin
            state <= rsu_pkg::read_mode_eval;
          end
        end
        rsu_pkg::read_mode_eval: begin
          app_mode_q <= rd_app_mode;
          if (rd_app_mode || cfg.force_factory) begin
            state <= rsu_pkg::done;
          end else begin
            state <= rsu_pkg::read_status_req;
          end
        end
        rsu_pkg::read_status_req: begin
          state <= rsu_pkg::read_status_wait;
        end
        rsu_pkg::read_status_wait: begin
          if (!busy) begin
            state <= rsu_pkg::read_status_eval;
          end
        end
        rsu_pkg::read_status_eval: begin
          cause_q <= rd_cause;
          // any error cause keeps us in the factory image
          if (rd_cause == '0) begin
            state <= rsu_pkg::write_wd_req;
          end else begin
            state <= rsu_pkg::done;
          end
        end
        rsu_pkg::write_wd_req: begin
          state <= rsu_pkg::write_wd_wait;
        end
        rsu_pkg::write_wd_wait: begin
          if (!busy) begin
            state <= rsu_pkg::write_addr_req;
          end
        end
        rsu_pkg::write_addr_req: begin
          state <= rsu_pkg::write_addr_wait;
        end
        rsu_pkg::write_addr_wait: begin
          if (!busy) begin
            state <= rsu_pkg::reconfig;
          end
        end
        rsu_pkg::reconfig: begin
          state <= rsu_pkg::reconfig;
        end
        rsu_pkg::done: begin
          // host-requested reboot from the factory image
          if (cfg.reboot_req) begin
            state <= rsu_pkg::reconfig;
          end
        end
        default: begin
          state <= rsu_pkg::idle_wait;
        end
      endcase
    end
  end

  // write payload, latched so it stays put while the core is busy
  always_ff @(posedge clk) begin
    if (state == rsu_pkg::read_status_eval) begin
      data_q <= cfg.watchdog;
    end else if (state == rsu_pkg::write_wd_wait && !busy) begin
      data_q <= cfg.boot_addr;
    end
  end

  // watchdog reset input of the core expects a toggle every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_q <= 1'b0;
    end else begin
      timer_q <= !timer_q;
    end
  end

  always_comb begin
    core_req             = '0;
    core_req.reset_timer = timer_q;
    case (state)
      rsu_pkg::read_mode_req: begin
        core_req.read_param  = 1'b1;
        core_req.param       = rsu_pkg::param_mode;
        core_req.read_source = rsu_pkg::src_current;
      end
      rsu_pkg::read_mode_wait: begin
        core_req.param       = rsu_pkg::param_mode;
        core_req.read_source = rsu_pkg::src_current;
      end
      rsu_pkg::read_status_req: begin
        core_req.read_param  = 1'b1;
        core_req.param       = rsu_pkg::param_cause;
        core_req.read_source = rsu_pkg::src_previous;
      end
      rsu_pkg::read_status_wait: begin
        core_req.param       = rsu_pkg::param_cause;
        core_req.read_source = rsu_pkg::src_previous;
      end
      rsu_pkg::write_wd_req: begin
        core_req.write_param = 1'b1;
        core_req.param       = rsu_pkg::param_wdog;
        core_req.data_in     = data_q;
      end
      rsu_pkg::write_wd_wait: begin
        core_req.param       = rsu_pkg::param_wdog;
        core_req.data_in     = data_q;
      end
      rsu_pkg::write_addr_req: begin
        core_req.write_param = 1'b1;
        core_req.param       = rsu_pkg::param_boot;
        core_req.data_in     = data_q;
      end
      rsu_pkg::write_addr_wait: begin
        core_req.param       = rsu_pkg::param_boot;
        core_req.data_in     = data_q;
      end
      rsu_pkg::reconfig: begin
        // terminal, held until rst
        core_req.reconfig    = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    status.state    = state;
    status.app_mode = app_mode_q;
    status.cause    = cause_q;
    status.finished = (state == rsu_pkg::done) || (state == rsu_pkg::reconfig);
  end

  strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(core_req.read_param && core_req.write_param));

  // core samples param for the whole busy period
  param_held_busy: assert property (@(posedge clk) disable iff (rst)
    core_rsp.busy |=> $stable(core_req.param));

endmodule

`default_nettype wire

/* hdl/rsu_csr.sv */
// Wishbone classic register block: control, boot address, watchdog, sequencer status
`timescale 1ns/1ps
`default_nettype none

module rsu_csr #(
  parameter rsu_pkg::rsu_data_t reset_boot_addr = 24'h100000,
  parameter rsu_pkg::rsu_data_t reset_watchdog  = 24'h000010
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  rsu_pkg::wb_adr_t     wb_adr,
  input  rsu_pkg::wb_data_t    wb_dat_w,
  output rsu_pkg::wb_data_t    wb_dat_r,
  output logic                 wb_ack,
  input  rsu_pkg::rsu_status_t status,
  output rsu_pkg::rsu_cfg_t    cfg
);

  logic               access;
  logic               force_factory_q;
  logic               reboot_q;
  rsu_pkg::rsu_data_t boot_q;
  rsu_pkg::rsu_data_t wdog_q;
  rsu_pkg::wb_data_t  rd_data;

  // single-cycle ack, no wait states
  assign access = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack          <= 1'b0;
      force_factory_q <= 1'b0;
      reboot_q        <= 1'b0;
      boot_q          <= reset_boot_addr;
      wdog_q          <= reset_watchdog;
    end else begin
      wb_ack   <= access;
      reboot_q <= 1'b0;
      if (access && wb_we) begin
        case (wb_adr)
          rsu_pkg::reg_ctrl: begin
            force_factory_q <= wb_dat_w[0];
            // reboot bit is a pulse, never stored
            reboot_q        <= wb_dat_w[1];
          end
          rsu_pkg::reg_boot: begin
            boot_q <= wb_dat_w[rsu_pkg::rsu_data_w-1:0];
          end
          rsu_pkg::reg_wdog: begin
            wdog_q <= wb_dat_w[rsu_pkg::rsu_data_w-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      rsu_pkg::reg_ctrl:   rd_data[0] = force_factory_q;
      rsu_pkg::reg_boot:   rd_data[rsu_pkg::rsu_data_w-1:0] = boot_q;
      rsu_pkg::reg_wdog:   rd_data[rsu_pkg::rsu_data_w-1:0] = wdog_q;
      rsu_pkg::reg_status: rd_data[$bits(rsu_pkg::rsu_status_t)-1:0] = status;
      default: begin
      end
    endcase
  end

  // read data captured with the ack, held while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      wb_dat_r <= rd_data;
    end
  end

  assign cfg = '{
    boot_addr:     boot_q,
    watchdog:      wdog_q,
    force_factory: force_factory_q,
    reboot_req:    reboot_q
  };

  // master holds stb until it has seen the ack
  ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_stb);

endmodule

`default_nettype wire

/* hdl/rsu_top.sv */
// remote-update top: register block and sequencer, exposing bus and update core ports
`timescale 1ns/1ps
`default_nettype none

module rsu_top #(
  parameter rsu_pkg::rsu_data_t reset_boot_addr = 24'h100000,
  parameter rsu_pkg::rsu_data_t reset_watchdog  = 24'h000010
) (
  input  logic                   clk,
  input  logic                   rst,
  // Wishbone classic slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  rsu_pkg::wb_adr_t       wb_adr,
  input  rsu_pkg::wb_data_t      wb_dat_w,
  output rsu_pkg::wb_data_t      wb_dat_r,
  output logic                   wb_ack,
  // update core
  output rsu_pkg::rsu_core_req_t core_req,
  input  rsu_pkg::rsu_core_rsp_t core_rsp
);

  rsu_pkg::rsu_cfg_t    cfg;
  rsu_pkg::rsu_status_t status;

  rsu_csr #(
    .reset_boot_addr (reset_boot_addr),
    .reset_watchdog  (reset_watchdog)
  ) rsu_csr_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .status   (status),
    .cfg      (cfg)
  );

  rsu_sequencer rsu_sequencer_i (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .core_rsp (core_rsp),
    .core_req (core_req),
    .status   (status)
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* verification/rsu_core_model.sv */
// behavioral remote-update core: busy timing, parameter readback, write and reconfig log
`timescale 1ns/1ps
`default_nettype none

module rsu_core_model #(
  parameter logic [7:0] startup_cycles = 8'd40
) (
  input  logic                         clk,
  input  logic                         rst,
  input  rsu_pkg::rsu_core_req_t       core_req,
  output rsu_pkg::rsu_core_rsp_t       core_rsp,
  input  rsu_pkg::rsu_readback_t       mode_rb,
  input  rsu_pkg::rsu_readback_t       cause_rb,
  input  logic [7:0]                   busy_len,
  output rsu_pkg::rsu_param_t [3:0]    wr_param,
  output rsu_pkg::rsu_data_t [3:0]     wr_data,
  output logic [3:0]                   wr_count,
  output logic [3:0]                   rd_count,
  output logic                         reconfig_seen
);

  logic [7:0]             busy_cnt;
  rsu_pkg::rsu_readback_t rd_value;
  rsu_pkg::rsu_readback_t rd_pending;

  // each parameter reads back only from its own source
  always_comb begin
    case (core_req.param)
      rsu_pkg::param_mode: begin
        rd_value = (core_req.read_source == rsu_pkg::src_current) ? mode_rb : '0;
      end
      rsu_pkg::param_cause: begin
        rd_value = (core_req.read_source == rsu_pkg::src_previous) ? cause_rb : '0;
      end
      default: begin
        rd_value = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // core comes out of its own reset busy, gives the host time to configure
      core_rsp.busy     <= 1'b1;
      core_rsp.data_out <= '0;
      busy_cnt          <= startup_cycles;
      rd_pending        <= '0;
      wr_count          <= '0;
      rd_count          <= '0;
      reconfig_seen     <= 1'b0;
    end else begin
      if (core_req.read_param || core_req.write_param) begin
        core_rsp.busy <= (busy_len != 8'd0);
        busy_cnt      <= busy_len;
      end else if (core_rsp.busy) begin
        busy_cnt <= busy_cnt - 8'd1;
        if (busy_cnt <= 8'd1) begin
          core_rsp.busy     <= 1'b0;
          core_rsp.data_out <= rd_pending;
        end
      end
      if (core_req.read_param) begin
        rd_count   <= rd_count + 4'd1;
        rd_pending <= rd_value;
        // readback is garbage until busy falls
        core_rsp.data_out <= (busy_len != 8'd0) ? '1 : rd_value;
      end
      if (core_req.write_param) begin
        wr_param[wr_count[1:0]] <= core_req.param;
        wr_data[wr_count[1:0]]  <= core_req.data_in;
        wr_count                <= wr_count + 4'd1;
      end
      // sticky until the next reset
      if (core_req.reconfig) begin
        reconfig_seen <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_rsu_top.sv */
// testbench top: trace reader, Wishbone master, result checks and run timeout
`timescale 1ns/1ps
`default_nettype none

module tb_rsu_top;

  localparam rsu_pkg::rsu_data_t boot_reset = 24'h0c0000;
  localparam rsu_pkg::rsu_data_t wdog_reset = 24'h000123;
  // reset plus the longest scenario, with margin
  localparam int cycles_per_record = 16 + 300;
  localparam int ack_wait_limit    = 8;
  localparam int hold_cycles       = 20;

  typedef struct packed {
    rsu_pkg::rsu_readback_t mode_rb;
    rsu_pkg::rsu_readback_t cause_rb;
    logic [7:0]             busy;
    logic                   force_factory;
    rsu_pkg::rsu_data_t     boot;
    rsu_pkg::rsu_data_t     wdog;
    logic                   reboot;
    logic                   exp_reconfig;
    logic [3:0]             exp_writes;
    logic [3:0]             exp_reads;
    logic                   exp_app;
    rsu_pkg::rsu_cause_t    exp_cause;
    logic [3:0]             exp_state;
  } record_t;

  logic                      clk;
  logic                      rst;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  rsu_pkg::wb_adr_t          wb_adr;
  rsu_pkg::wb_data_t         wb_dat_w;
  rsu_pkg::wb_data_t         wb_dat_r;
  logic                      wb_ack;
  rsu_pkg::rsu_core_req_t    core_req;
  rsu_pkg::rsu_core_rsp_t    core_rsp;
  rsu_pkg::rsu_readback_t    mode_rb;
  rsu_pkg::rsu_readback_t    cause_rb;
  logic [7:0]                busy_len;
  rsu_pkg::rsu_param_t [3:0] wr_param;
  rsu_pkg::rsu_data_t [3:0]  wr_data;
  logic [3:0]                wr_count;
  logic [3:0]                rd_count;
  logic                      reconfig_seen;
  logic                      timer_prev = 1'b0;
  logic                      rst_prev   = 1'b1;

  record_t recs[$];
  int      errors      = 0;
  int      cycles      = 0;
  int      cycle_limit = 0;
  int      rec_idx     = 0;

  tb_clock #(.period_ns(40)) tb_clock_i (.clk(clk));

  rsu_top #(
    .reset_boot_addr (boot_reset),
    .reset_watchdog  (wdog_reset)
  ) rsu_top_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .core_req (core_req),
    .core_rsp (core_rsp)
  );

  rsu_core_model rsu_core_model_i (
    .clk           (clk),
    .rst           (rst),
    .core_req      (core_req),
    .core_rsp      (core_rsp),
    .mode_rb       (mode_rb),
    .cause_rb      (cause_rb),
    .busy_len      (busy_len),
    .wr_param      (wr_param),
    .wr_data       (wr_data),
    .wr_count      (wr_count),
    .rd_count      (rd_count),
    .reconfig_seen (reconfig_seen)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0t: record %0d %s is %0h, expected %0h",
             $time, rec_idx, what, got, exp);
  endtask

  // watchdog reset toggle, checked once reset has been low for a cycle
  always @(posedge clk) begin
    timer_prev <= core_req.reset_timer;
    rst_prev   <= rst;
    if (!rst && !rst_prev && core_req.reset_timer === timer_prev) begin
      report_mismatch("reset_timer", 32'(core_req.reset_timer), 32'(!timer_prev));
    end
  end

  task automatic bus_access(input rsu_pkg::wb_adr_t adr, input logic we,
                            input rsu_pkg::wb_data_t wdata, output rsu_pkg::wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && waited < ack_wait_limit) begin
      waited++;
      @(negedge clk);
    end
    if (!wb_ack) begin
      errors++;
      $display("bus access to register %0d got no ack at %0t", adr, $time);
    end else begin
      rdata = wb_dat_r;
    end
    // stb held through the ack edge, a second ack would show here
    @(negedge clk);
    if (wb_ack) begin
      errors++;
      $display("bus access to register %0d was acked twice at %0t", adr, $time);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input rsu_pkg::wb_adr_t adr, input rsu_pkg::wb_data_t wdata);
    rsu_pkg::wb_data_t unused;
    bus_access(adr, 1'b1, wdata, unused);
  endtask

  task automatic bus_read(input rsu_pkg::wb_adr_t adr, output rsu_pkg::wb_data_t rdata);
    bus_access(adr, 1'b0, '0, rdata);
  endtask

  task automatic run_record(input record_t r);
    rsu_pkg::wb_data_t d;
    rsu_pkg::wb_data_t st;
    int                bad;
    @(negedge clk);
    rst      = 1'b1;
    mode_rb  = r.mode_rb;
    cause_rb = r.cause_rb;
    busy_len = r.busy;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    bus_read(rsu_pkg::reg_boot, d);
    if (d !== 32'(boot_reset)) report_mismatch("boot reset value", d, 32'(boot_reset));
    bus_read(rsu_pkg::reg_wdog, d);
    if (d !== 32'(wdog_reset)) report_mismatch("watchdog reset value", d, 32'(wdog_reset));
    bus_write(rsu_pkg::reg_ctrl, 32'(r.force_factory));
    bus_write(rsu_pkg::reg_boot, 32'(r.boot));
    bus_write(rsu_pkg::reg_wdog, 32'(r.wdog));
    bus_read(rsu_pkg::reg_ctrl, d);
    if (d !== 32'(r.force_factory)) report_mismatch("ctrl readback", d, 32'(r.force_factory));
    bus_read(rsu_pkg::reg_boot, d);
    if (d !== 32'(r.boot)) report_mismatch("boot readback", d, 32'(r.boot));
    bus_read(rsu_pkg::reg_wdog, d);
    if (d !== 32'(r.wdog)) report_mismatch("watchdog readback", d, 32'(r.wdog));
    // finished is also set in the reconfig state
    st = '0;
    while (!st[9]) begin
      bus_read(rsu_pkg::reg_status, st);
    end
    if (st[3:0] !== r.exp_state) report_mismatch("state", 32'(st[3:0]), 32'(r.exp_state));
    if (st[4] !== r.exp_app) report_mismatch("app_mode", 32'(st[4]), 32'(r.exp_app));
    if (st[8:5] !== r.exp_cause) report_mismatch("cause", 32'(st[8:5]), 32'(r.exp_cause));
    if (rd_count !== r.exp_reads) report_mismatch("core reads", 32'(rd_count), 32'(r.exp_reads));
    if (r.reboot) begin
      bus_write(rsu_pkg::reg_ctrl, {30'h0, 1'b1, r.force_factory});
      if (core_req.reconfig !== 1'b1) begin
        report_mismatch("reconfig after reboot", 32'(core_req.reconfig), 32'd1);
      end
    end
    bad = 0;
    repeat (hold_cycles) begin
      @(negedge clk);
      if (core_req.reconfig !== r.exp_reconfig) bad++;
    end
    if (bad != 0) report_mismatch("cycles with wrong reconfig", 32'(bad), 32'd0);
    if (reconfig_seen !== r.exp_reconfig) begin
      report_mismatch("reconfig seen", 32'(reconfig_seen), 32'(r.exp_reconfig));
    end
    if (wr_count !== r.exp_writes) begin
      report_mismatch("core writes", 32'(wr_count), 32'(r.exp_writes));
    end else if (r.exp_writes == 4'd2) begin
      // watchdog first, then the boot address
      if (wr_param[0] !== rsu_pkg::param_wdog) report_mismatch("first write param",
        32'(wr_param[0]), 32'(rsu_pkg::param_wdog));
      if (wr_data[0] !== r.wdog) report_mismatch("first write data", 32'(wr_data[0]), 32'(r.wdog));
      if (wr_param[1] !== rsu_pkg::param_boot) report_mismatch("second write param",
        32'(wr_param[1]), 32'(rsu_pkg::param_boot));
      if (wr_data[1] !== r.boot) report_mismatch("second write data", 32'(wr_data[1]), 32'(r.boot));
    end
  endtask

  initial begin
    logic [8*160-1:0] line;
    logic [31:0]      f [13];
    record_t          r;
    int               fd;
    int               code;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    mode_rb  = '0;
    cause_rb = '0;
    busy_len = '0;
    fd = $fopen("verification/rsu_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file verification/rsu_trace.txt");
      $display("Something failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        code = $fgets(line, fd);
        code = $sscanf(line, "%h %h %d %d %h %h %d %d %d %d %d %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                       f[7], f[8], f[9], f[10], f[11], f[12]);
        // comment and blank lines do not scan
        if (code == 13) begin
          r.mode_rb       = f[0][28:0];
          r.cause_rb      = f[1][28:0];
          r.busy          = f[2][7:0];
          r.force_factory = f[3][0];
          r.boot          = f[4][23:0];
          r.wdog          = f[5][23:0];
          r.reboot        = f[6][0];
          r.exp_reconfig  = f[7][0];
          r.exp_writes    = f[8][3:0];
          r.exp_reads     = f[9][3:0];
          r.exp_app       = f[10][0];
          r.exp_cause     = f[11][3:0];
          r.exp_state     = f[12][3:0];
          recs.push_back(r);
        end
      end
      $fclose(fd);
      if (recs.size() == 0) begin
        errors++;
        $display("the trace file holds no records");
      end
      cycle_limit = recs.size() * cycles_per_record;
      foreach (recs[i]) begin
        rec_idx = i;
        run_record(recs[i]);
      end
      $display("records: %0d, errors: %0d", recs.size(), errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/rsu_trace.txt */
# mode_rb cause_rb busy force boot wdog reboot | expected: reconfig writes reads app cause state
# hex: mode_rb cause_rb boot wdog cause state; decimal: busy force reboot reconfig writes reads app
# application image already running
00000001 00000000 3 0 200000 000100 0 0 0 1 1 0 c
# factory image, clean previous config
00000000 00000000 5 0 2a0000 0003ff 0 1 2 2 0 0 b
# factory image, error cause 5
00000000 0000000a 4 0 300000 000200 0 0 0 2 0 5 c
# host forced factory mode
00000000 00000000 2 1 310000 000040 0 0 0 1 0 0 c
# error cause 9, then host reboot from done
00000000 00000012 6 0 320000 000080 1 1 0 2 0 9 c
# clean config, core never busy
00000000 00000000 0 0 0abcde 123456 0 1 2 2 0 0 b
# application mode with upper readback bits set
0000ffe1 00000000 12 0 330000 000011 0 0 0 1 1 0 c
# forced factory, then host reboot
00000000 00000000 1 1 400000 000020 1 1 0 1 0 0 c
# cause field zero, other readback bits set
00000000 000001e0 12 0 4a0000 00ffff 0 1 2 2 0 0 b
# error cause 1
00000000 00000002 7 0 500000 000300 0 0 0 2 0 1 c

/* verilog.f */
hdl/rsu_pkg.sv
hdl/rsu_sequencer.sv
hdl/rsu_csr.sv
hdl/rsu_top.sv
verification/tb_clock.sv
verification/rsu_core_model.sv
verification/tb_rsu_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_rsu_top -f verilog.f
out="$(./obj_dir/Vtb_rsu_top)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
